//--- tb.f
source/dtlb_addr_pkg.sv
source/dtlb_cache_pkg.sv
source/tlb_ram.sv
source/dtlb_ctrl.sv
source/dtlb_way_match.sv
source/dtlb_evict.sv
source/dtlb_top.sv
sim/ptw_model.sv
sim/dtlb_tb.sv

//--- Bender.yml
package:
  name: dtlb

sources:
  - source/dtlb_addr_pkg.sv
  - source/dtlb_cache_pkg.sv
  - source/tlb_ram.sv
  - source/dtlb_ctrl.sv
  - source/dtlb_way_match.sv
  - source/dtlb_evict.sv
  - source/dtlb_top.sv
  - target: test
    files:
      - sim/ptw_model.sv
      - sim/dtlb_tb.sv

//--- sim/dtlb_tb.sv
`timescale 1ns/100ps
`default_nettype none

// Directed tests of the DTLB against a behavioral walker
module dtlb_tb;

   import dtlb_addr_pkg::*;
   import dtlb_cache_pkg::*;

   // Longest wait for any handshake, in cycles
   localparam int TIMEOUT = 50;
   localparam int NUM_HOT = 4;

   // Three pages that share set 0x15
   localparam logic [VPN_BITS-1:0] PAGE_A = 20'h01115;
   localparam logic [VPN_BITS-1:0] PAGE_B = 20'h2A455;
   localparam logic [VPN_BITS-1:0] PAGE_C = 20'hC0F95;

   logic                    clk;
   logic                    rst_n;
   vpn_u                    vaddr;
   logic                    re;
   logic [PAGEDIR_BITS-1:0] pagedir_base;
   logic                    ready;
   logic                    resp_valid;
   logic [PPN_BITS-1:0]     paddr;
   logic [FLAG_BITS-1:0]    flags;
   logic [VPN_BITS-1:0]     ptw_addr;
   logic                    ptw_re;
   logic [PAGEDIR_BITS-1:0] ptw_pagedir_base;
   logic [PPN_BITS-1:0]     ptw_phys_addr;
   logic                    ptw_ready;
   logic [FLAG_BITS-1:0]    ptw_pagetab_flags;
   logic [FLAG_BITS-1:0]    ptw_pagedir_flags;
   int                      walk_count;

   // Pages in distinct sets for the hit stream
   logic [VPN_BITS-1:0]     hot [NUM_HOT];

   dtlb_top u_dut (
      .clk (clk), .rst_n (rst_n), .vaddr (vaddr), .re (re), .pagedir_base (pagedir_base),
      .ptw_phys_addr (ptw_phys_addr), .ptw_ready (ptw_ready),
      .ptw_pagetab_flags (ptw_pagetab_flags), .ptw_pagedir_flags (ptw_pagedir_flags),
      .ready (ready), .resp_valid (resp_valid), .paddr (paddr), .flags (flags),
      .ptw_addr (ptw_addr), .ptw_re (ptw_re), .ptw_pagedir_base (ptw_pagedir_base)
   );

   ptw_model u_ptw (
      .clk (clk), .rst_n (rst_n), .ptw_addr (ptw_addr), .ptw_re (ptw_re),
      .ptw_phys_addr (ptw_phys_addr), .ptw_ready (ptw_ready),
      .ptw_pagetab_flags (ptw_pagetab_flags), .ptw_pagedir_flags (ptw_pagedir_flags),
      .walk_count (walk_count)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // Walker rule for the physical page
   function automatic logic [PPN_BITS-1:0] walk_ppn(input logic [VPN_BITS-1:0] vpn);
      return vpn ^ 20'hA5A5A;
   endfunction

   // Present and writeable need both levels, kernel and global come from either
   function automatic logic [FLAG_BITS-1:0] merged_flags(input logic [VPN_BITS-1:0] vpn);
      logic [FLAG_BITS-1:0] dir;
      logic [FLAG_BITS-1:0] tab;
      dir = vpn[3:0];
      tab = vpn[7:4];
      return {dir[3] | tab[3], dir[2] | tab[2], dir[1] & tab[1], dir[0] & tab[0]};
   endfunction

   task automatic abort_run();
      $display("STATUS: FAIL");
      $fatal(1, "Stopped at the first error");
   endtask

   task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         $display("[FAIL] t=%0t %s got=0x%0h exp=0x%0h", $time, name, got, exp);
         abort_run();
      end
   endtask

   task automatic timed_out(input string what);
      $display("Timed out after %0d cycles waiting for %s", TIMEOUT, what);
      abort_run();
   endtask

   // Offer a page at a rising edge, then sample at falling edges until ready
   task automatic offer(input logic [VPN_BITS-1:0] vpn);
      int waited;
      waited = 0;
      @(posedge clk);
      vaddr.raw <= vpn;
      re        <= 1'b1;
      @(negedge clk);
      while (!ready) begin
         waited++;
         if (waited > TIMEOUT) begin
            timed_out("ready to take a request");
         end
         @(negedge clk);
      end
   endtask

   // One request from offer to response
   task automatic run_request(input logic [VPN_BITS-1:0] vpn, input logic expect_hit);
      int cycles;
      int pulses;
      int walks_before;
      cycles = 0;
      pulses = 0;
      walks_before = walk_count;
      offer(vpn);
      // Taken on this edge, the request bus moves on at once
      @(posedge clk);
      re        <= 1'b0;
      vaddr.raw <= ~vpn;
      @(negedge clk);
      // Walk outstanding, requester held off and walker address steady
      while (!resp_valid) begin
         if (ptw_re) begin
            pulses++;
         end
         check("ready", ready, 1'b0);
         check("ptw_addr", ptw_addr, vpn);
         check("ptw_pagedir_base", ptw_pagedir_base, pagedir_base);
         cycles++;
         if (cycles > TIMEOUT) begin
            timed_out("resp_valid after a miss");
         end
         @(posedge clk);
         // Request bus and directory base move while the walk runs
         vaddr.raw    <= vaddr.raw + 20'h00041;
         pagedir_base <= pagedir_base + 20'h01001;
         @(negedge clk);
      end
      check("paddr", paddr, walk_ppn(vpn));
      check("flags", flags, merged_flags(vpn));
      check("ready", ready, 1'b1);
      check("ptw_pagedir_base", ptw_pagedir_base, pagedir_base);
      check("walk_count", walk_count, walks_before + (expect_hit ? 0 : 1));
      check("ptw_re pulses", pulses, expect_hit ? 0 : 1);
      if (expect_hit) begin
         // Hit answers one cycle after acceptance
         check("hit latency", cycles, 0);
      end
   endtask

   task automatic idle_after_reset();
      int waited;
      waited = 0;
      @(negedge clk);
      while (!ready) begin
         waited++;
         if (waited > TIMEOUT) begin
            timed_out("ready after reset");
         end
         @(negedge clk);
      end
      check("resp_valid", resp_valid, 1'b0);
      check("ptw_re", ptw_re, 1'b0);
      check("ptw_pagedir_base", ptw_pagedir_base, pagedir_base);
   endtask

   task automatic miss_then_hit();
      run_request(hot[0], 1'b0);
      run_request(hot[0], 1'b1);
   endtask

   task automatic back_to_back_hits();
      logic [VPN_BITS-1:0] pending [$];
      logic [VPN_BITS-1:0] exp_vpn;
      int                  i;
      int                  sent;
      int                  walks_before;
      sent = 0;
      // Fill the rest of the hot pages first
      for (i = 1; i < NUM_HOT; i++) begin
         run_request(hot[i], 1'b0);
      end
      walks_before = walk_count;
      offer(hot[0]);
      // re held high, one request per edge and one response per cycle
      while (sent < NUM_HOT || pending.size() > 0) begin
         if (pending.size() > 0) begin
            exp_vpn = pending.pop_front();
            check("resp_valid", resp_valid, 1'b1);
            check("paddr", paddr, walk_ppn(exp_vpn));
            check("flags", flags, merged_flags(exp_vpn));
         end
         if (sent < NUM_HOT) begin
            check("ready", ready, 1'b1);
         end
         @(posedge clk);
         if (sent < NUM_HOT) begin
            pending.push_back(hot[sent]);
            sent++;
            if (sent < NUM_HOT) begin
               vaddr.raw <= hot[sent];
            end else begin
               re <= 1'b0;
            end
         end
         @(negedge clk);
      end
      check("walk_count", walk_count, walks_before);
   endtask

   task automatic same_set_eviction();
      run_request(PAGE_A, 1'b0);
      run_request(PAGE_B, 1'b0);
      run_request(PAGE_A, 1'b1);
      // B sits in the way not hit last, so C replaces it
      run_request(PAGE_C, 1'b0);
      run_request(PAGE_A, 1'b1);
      run_request(PAGE_B, 1'b0);
   endtask

   initial begin
      rst_n        = 1'b0;
      re           = 1'b0;
      vaddr        = '0;
      pagedir_base = 20'h1F000;
      hot[0]       = 20'h3C4F7;
      hot[1]       = 20'h0A1B2;
      hot[2]       = 20'hFEDC9;
      hot[3]       = 20'h55AA0;
      repeat (10) @(posedge clk);
      rst_n <= 1'b1;
      idle_after_reset();
      miss_then_hit();
      back_to_back_hits();
      same_set_eviction();
      $display("STATUS: PASS");
      $finish;
   end

endmodule

`default_nettype wire

//--- sim/ptw_model.sv
`timescale 1ns/100ps
`default_nettype none

// Behavioral page table walker
// Serves one walk at a time and answers after 2 to 7 cycles
module ptw_model (
   input  wire                                 clk,
   input  wire                                 rst_n,
   input  wire  [dtlb_addr_pkg::VPN_BITS-1:0]  ptw_addr,
   input  wire                                 ptw_re,
   output logic [dtlb_addr_pkg::PPN_BITS-1:0]  ptw_phys_addr,
   output logic                                ptw_ready,
   output logic [dtlb_addr_pkg::FLAG_BITS-1:0] ptw_pagetab_flags,
   output logic [dtlb_addr_pkg::FLAG_BITS-1:0] ptw_pagedir_flags,
   output int                                  walk_count
);

   import dtlb_addr_pkg::*;

   int                  seed;
   int                  draw;
   int                  delay_left;
   logic                busy;
   logic [VPN_BITS-1:0] walk_vpn;

   initial begin
      seed = 36;
   end

   always @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         ptw_phys_addr     <= '0;
         ptw_ready         <= 1'b0;
         ptw_pagetab_flags <= '0;
         ptw_pagedir_flags <= '0;
         walk_count        <= 0;
         delay_left        <= 0;
         busy              <= 1'b0;
         walk_vpn          <= '0;
      end else begin
         // Ready is a single pulse, the result stays until the next answer
         ptw_ready <= 1'b0;
         if (busy) begin
            if (delay_left <= 1) begin
               ptw_ready         <= 1'b1;
               ptw_phys_addr     <= walk_vpn ^ 20'hA5A5A;
               // Directory flags in the low nibble, table flags above them
               ptw_pagedir_flags <= walk_vpn[3:0];
               ptw_pagetab_flags <= walk_vpn[7:4];
               busy              <= 1'b0;
            end else begin
               delay_left <= delay_left - 1;
            end
         end else if (ptw_re) begin
            draw = $random(seed);
            delay_left <= 2 + ((draw & 32'h7fff_ffff) % 6);
            walk_vpn   <= ptw_addr;
            busy       <= 1'b1;
            walk_count <= walk_count + 1;
         end
      end
   end

endmodule

`default_nettype wire

//--- source/dtlb_top.sv
`timescale 1ns/100ps
`default_nettype none

// Data TLB, one lookup port, two-way cache, refill through the page walker
module dtlb_top (
   input  wire                                        clk,
   input  wire                                        rst_n,
   input  wire dtlb_cache_pkg::vpn_u                  vaddr,
   input  wire                                        re,
   input  wire  [dtlb_addr_pkg::PAGEDIR_BITS-1:0]     pagedir_base,
   input  wire  [dtlb_addr_pkg::PPN_BITS-1:0]         ptw_phys_addr,
   input  wire                                        ptw_ready,
   input  wire  [dtlb_addr_pkg::FLAG_BITS-1:0]        ptw_pagetab_flags,
   input  wire  [dtlb_addr_pkg::FLAG_BITS-1:0]        ptw_pagedir_flags,
   output logic                                       ready,
   output logic                                       resp_valid,
   output logic [dtlb_addr_pkg::PPN_BITS-1:0]         paddr,
   output logic [dtlb_addr_pkg::FLAG_BITS-1:0]        flags,
   output logic [dtlb_addr_pkg::VPN_BITS-1:0]         ptw_addr,
   output logic                                       ptw_re,
   output logic [dtlb_addr_pkg::PAGEDIR_BITS-1:0]     ptw_pagedir_base
);

   import dtlb_cache_pkg::*;

   logic [SET_BITS-1:0] rd_set;
   vpn_u                req_vpn;
   logic                refill;
   logic                evict_from_hit;
   logic                evict_from_miss;
   logic                hit;
   logic                hit_way;
   logic                victim_way;

   // Directory base is only used by the walker
   assign ptw_pagedir_base = pagedir_base;

   dtlb_ctrl u_ctrl (
      .clk             (clk),
      .rst_n           (rst_n),
      .vaddr           (vaddr),
      .re              (re),
      .hit             (hit),
      .ptw_ready       (ptw_ready),
      .ready           (ready),
      .resp_valid      (resp_valid),
      .rd_set          (rd_set),
      .req_vpn         (req_vpn),
      .refill          (refill),
      .evict_from_hit  (evict_from_hit),
      .evict_from_miss (evict_from_miss),
      .ptw_addr        (ptw_addr),
      .ptw_re          (ptw_re)
   );

   // Responses come straight from the way memories
   dtlb_way_match #(
      .DATA_WIDTH (ENTRY_BITS),
      .ADDR_WIDTH (SET_BITS)
   ) u_way_match (
      .clk               (clk),
      .rst_n             (rst_n),
      .rd_set            (rd_set),
      .req_vpn           (req_vpn),
      .refill            (refill),
      .victim_way        (victim_way),
      .ptw_phys_addr     (ptw_phys_addr),
      .ptw_pagetab_flags (ptw_pagetab_flags),
      .ptw_pagedir_flags (ptw_pagedir_flags),
      .hit               (hit),
      .hit_way           (hit_way),
      .ppn               (paddr),
      .flags             (flags)
   );

   dtlb_evict #(
      .ADDR_WIDTH (SET_BITS)
   ) u_evict (
      .clk             (clk),
      .rst_n           (rst_n),
      .rd_set          (rd_set),
      .evict_from_hit  (evict_from_hit),
      .evict_from_miss (evict_from_miss),
      .hit_way         (hit_way),
      .victim_way      (victim_way)
   );

endmodule

`default_nettype wire

//--- source/dtlb_evict.sv
`timescale 1ns/100ps
`default_nettype none

// Per-set eviction bit
// Names the way that the next refill of the set replaces
module dtlb_evict #(
   parameter int ADDR_WIDTH = 6
) (
   input  wire                  clk,
   input  wire                  rst_n,
   input  wire [ADDR_WIDTH-1:0] rd_set,
   input  wire                  evict_from_hit,
   input  wire                  evict_from_miss,
   input  wire                  hit_way,
   output logic                 victim_way
);

   // Set read on the previous edge, which is the set of the current request
   logic [ADDR_WIDTH-1:0] upd_set;

   logic [ADDR_WIDTH-1:0] ram_addr;
   logic                  ram_we;
   logic                  ram_wdata;
   logic                  ram_rdata;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         upd_set <= '0;
      end else begin
         upd_set <= rd_set;
      end
   end

   assign ram_we = evict_from_hit | evict_from_miss;

   // Updates go to the request's set, reads follow the lookup set
   assign ram_addr = ram_we ? upd_set : rd_set;

   // Hit keeps the other way as victim
   // Refill flips the bit away from the way just written
   assign ram_wdata = evict_from_hit ? ~hit_way : ~ram_rdata;

   tlb_ram #(
      .DATA_WIDTH (1),
      .ADDR_WIDTH (ADDR_WIDTH)
   ) u_evict_ram (
      .clk   (clk),
      .rst_n (rst_n),
      .addr  (ram_addr),
      .wdata (ram_wdata),
      .we    (ram_we),
      .rdata (ram_rdata)
   );

   assign victim_way = ram_rdata;

endmodule

`default_nettype wire

//--- source/dtlb_way_match.sv
`timescale 1ns/100ps
`default_nettype none

// Two way memories with tag compare, hit select and refill entry build
module dtlb_way_match #(
   parameter int DATA_WIDTH = 39,
   parameter int ADDR_WIDTH = 6
) (
   input  wire                                      clk,
   input  wire                                      rst_n,
   input  wire  [ADDR_WIDTH-1:0]                    rd_set,
   input  wire dtlb_cache_pkg::vpn_u                req_vpn,
   input  wire                                      refill,
   input  wire                                      victim_way,
   input  wire  [dtlb_addr_pkg::PPN_BITS-1:0]       ptw_phys_addr,
   input  wire  [dtlb_addr_pkg::FLAG_BITS-1:0]      ptw_pagetab_flags,
   input  wire  [dtlb_addr_pkg::FLAG_BITS-1:0]      ptw_pagedir_flags,
   output logic                                     hit,
   output logic                                     hit_way,
   output logic [dtlb_addr_pkg::PPN_BITS-1:0]       ppn,
   output logic [dtlb_addr_pkg::FLAG_BITS-1:0]      flags
);

   import dtlb_addr_pkg::*;
   import dtlb_cache_pkg::*;

   logic [DATA_WIDTH-1:0] rdata [NUM_WAYS];
   logic [NUM_WAYS-1:0]   way_hit;
   logic [NUM_WAYS-1:0]   way_we;
   logic [FLAG_BITS-1:0]  merged_flags;
   logic [DATA_WIDTH-1:0] new_entry;

   // Access rights need both levels, attributes come from either level
   always_comb begin
      merged_flags = '0;
      merged_flags[FLAG_PRESENT] =
         ptw_pagedir_flags[FLAG_PRESENT] & ptw_pagetab_flags[FLAG_PRESENT];
      merged_flags[FLAG_WRITEABLE] =
         ptw_pagedir_flags[FLAG_WRITEABLE] & ptw_pagetab_flags[FLAG_WRITEABLE];
      merged_flags[FLAG_KERNEL] =
         ptw_pagedir_flags[FLAG_KERNEL] | ptw_pagetab_flags[FLAG_KERNEL];
      merged_flags[FLAG_GLOBAL] =
         ptw_pagedir_flags[FLAG_GLOBAL] | ptw_pagetab_flags[FLAG_GLOBAL];
   end

   // Refill entry, tag taken from the latched request
   always_comb begin
      new_entry = '0;
      new_entry[ENTRY_VALID_POS]                = 1'b1;
      new_entry[ENTRY_TAG_POS +: TAG_BITS]      = req_vpn.idx.tag;
      new_entry[ENTRY_FLAGS_POS +: FLAG_BITS]   = merged_flags;
      new_entry[ENTRY_PPN_POS +: PPN_BITS]      = ptw_phys_addr;
   end

   // Only the victim way is written
   assign way_we = refill ? ({{(NUM_WAYS-1){1'b0}}, 1'b1} << victim_way) : '0;

   for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
      tlb_ram #(
         .DATA_WIDTH (DATA_WIDTH),
         .ADDR_WIDTH (ADDR_WIDTH)
      ) u_way_ram (
         .clk   (clk),
         .rst_n (rst_n),
         .addr  (rd_set),
         .wdata (new_entry),
         .we    (way_we[w]),
         .rdata (rdata[w])
      );

      // Valid entry with a matching tag
      assign way_hit[w] = rdata[w][ENTRY_VALID_POS] &&
                          (rdata[w][ENTRY_TAG_POS +: TAG_BITS] == req_vpn.idx.tag);
   end

   assign hit     = |way_hit;
   assign hit_way = way_hit[1];
   assign ppn     = rdata[hit_way][ENTRY_PPN_POS +: PPN_BITS];
   assign flags   = rdata[hit_way][ENTRY_FLAGS_POS +: FLAG_BITS];

   // A page is only filled on a miss, so a set never holds it twice
   a_single_way_hit: assert property (@(posedge clk) disable iff (!rst_n)
      $onehot0(way_hit));

endmodule

`default_nettype wire

//--- source/dtlb_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

// Lookup FSM of the DTLB
// Latches each request, picks the set to read and drives the walker request
module dtlb_ctrl (
   input  wire                                     clk,
   input  wire                                     rst_n,
   input  wire dtlb_cache_pkg::vpn_u               vaddr,
   input  wire                                     re,
   input  wire                                     hit,
   input  wire                                     ptw_ready,
   output logic                                    ready,
   output logic                                    resp_valid,
   output logic [dtlb_cache_pkg::SET_BITS-1:0]     rd_set,
   output dtlb_cache_pkg::vpn_u                    req_vpn,
   output logic                                    refill,
   output logic                                    evict_from_hit,
   output logic                                    evict_from_miss,
   output logic [dtlb_addr_pkg::VPN_BITS-1:0]      ptw_addr,
   output logic                                    ptw_re
);

   // Nothing in flight
   localparam logic [1:0] ST_IDLE    = 2'd0;
   // Way data of the latched set is on the RAM outputs
   localparam logic [1:0] ST_COMPARE = 2'd1;
   // Walk outstanding, waiting for the walker
   localparam logic [1:0] ST_LOOKUP  = 2'd2;
   // Refilled entry being read back
   localparam logic [1:0] ST_REREAD  = 2'd3;

   logic [1:0] state;
   logic [1:0] state_nxt;

   // Holds ready low in the very first cycle after reset
   logic       out_of_reset;

   // Walker result seen on the previous edge
   logic       ptw_ready_q;

   logic       accept;

   // New request can be taken in IDLE, or behind a hit in COMPARE
   assign ready  = (state == ST_IDLE && out_of_reset) || (state == ST_COMPARE && hit);
   assign accept = re && ready;

   // Hit response goes out in the compare cycle
   assign resp_valid     = (state == ST_COMPARE) && hit;
   assign evict_from_hit = resp_valid;

   // Miss starts a walk, single-cycle pulse since COMPARE is left at once
   assign ptw_re = (state == ST_COMPARE) && !hit;

   // Walker stays on the latched page for the whole walk
   assign ptw_addr = req_vpn.raw;

   // Entry write one cycle after the walker result
   assign refill          = (state == ST_LOOKUP) && ptw_ready_q;
   assign evict_from_miss = refill;

   // Incoming set on acceptance, latched set otherwise
   assign rd_set = accept ? vaddr.idx.set_idx : req_vpn.idx.set_idx;

   always_comb begin
      state_nxt = state;
      case (state)
         ST_IDLE: begin
            if (accept) begin
               state_nxt = ST_COMPARE;
            end
         end
         ST_COMPARE: begin
            if (!hit) begin
               state_nxt = ST_LOOKUP;
            end else if (accept) begin
               // Back-to-back hit, next set already being read
               state_nxt = ST_COMPARE;
            end else begin
               state_nxt = ST_IDLE;
            end
         end
         ST_LOOKUP: begin
            if (ptw_ready_q) begin
               state_nxt = ST_REREAD;
            end
         end
         default: begin
            // REREAD, data of the refilled set is ready next cycle
            state_nxt = ST_COMPARE;
         end
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state        <= ST_IDLE;
         out_of_reset <= 1'b0;
         ptw_ready_q  <= 1'b0;
      end else begin
         state        <= state_nxt;
         out_of_reset <= 1'b1;
         ptw_ready_q  <= ptw_ready;
      end
   end

   // Request register, only loaded on acceptance
   always_ff @(posedge clk) begin
      if (accept) begin
         req_vpn <= vaddr;
      end
   end

   // Only one walk is started per miss
   a_ptw_re_pulse: assert property (@(posedge clk) disable iff (!rst_n)
      ptw_re |=> !ptw_re);

   // Walker address holds from the request through the whole walk
   a_ptw_addr_stable: assert property (@(posedge clk) disable iff (!rst_n)
      (state == ST_LOOKUP) |-> $stable(ptw_addr));

endmodule

`default_nettype wire

//--- source/tlb_ram.sv
`timescale 1ns/100ps
`default_nettype none

// Single-port flop memory, cleared on reset so every entry starts invalid
module tlb_ram #(
   parameter int DATA_WIDTH = 1,
   parameter int ADDR_WIDTH = 1
) (
   input  wire                   clk,
   input  wire                   rst_n,
   input  wire  [ADDR_WIDTH-1:0] addr,
   input  wire  [DATA_WIDTH-1:0] wdata,
   input  wire                   we,
   output logic [DATA_WIDTH-1:0] rdata
);

   logic [DATA_WIDTH-1:0] mem [2**ADDR_WIDTH];

   // Registered read, old data on a same-address write
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < 2**ADDR_WIDTH; i++) begin
            mem[i] <= '0;
         end
         rdata <= '0;
      end else begin
         if (we) begin
            mem[addr] <= wdata;
         end
         rdata <= mem[addr];
      end
   end

   // A refill never stores unknown bits into the array
   a_wdata_known: assert property (@(posedge clk) disable iff (!rst_n)
      we |-> !$isunknown(wdata));

endmodule

`default_nettype wire

//--- source/dtlb_cache_pkg.sv
`default_nettype none

// Geometry and entry layout of the two-way translation cache
package dtlb_cache_pkg;

   // 64 sets, indexed by the low bits of the virtual page
   localparam int SET_BITS = 6;
   localparam int TAG_BITS = dtlb_addr_pkg::VPN_BITS - SET_BITS;

   // Two ways with one eviction bit per set
   localparam int NUM_WAYS = 2;

   // Entry layout, from the top bit down
   // valid, tag, flags, physical page
   localparam int ENTRY_PPN_POS   = 0;
   localparam int ENTRY_FLAGS_POS = ENTRY_PPN_POS + dtlb_addr_pkg::PPN_BITS;
   localparam int ENTRY_TAG_POS   = ENTRY_FLAGS_POS + dtlb_addr_pkg::FLAG_BITS;
   localparam int ENTRY_VALID_POS = ENTRY_TAG_POS + TAG_BITS;
   localparam int ENTRY_BITS      = ENTRY_VALID_POS + 1;

   // One virtual page number seen two ways
   // raw goes to the walker, idx splits it for the cache lookup
   typedef union packed {
      logic [dtlb_addr_pkg::VPN_BITS-1:0] raw;
      struct packed {
         logic [TAG_BITS-1:0] tag;
         logic [SET_BITS-1:0] set_idx;
      } idx;
   } vpn_u;

endpackage

`default_nettype wire

//--- source/dtlb_addr_pkg.sv
`default_nettype none

// Page format of the 32-bit paged address space
package dtlb_addr_pkg;

   // Virtual page number, upper 20 bits of a virtual address
   localparam int VPN_BITS = 20;

   // Physical page number returned by the walker
   localparam int PPN_BITS = 20;

   // Permission and attribute bits of one page
   localparam int FLAG_BITS = 4;

   // Flag positions
   // Same layout for directory flags, table flags and merged flags
   localparam int FLAG_PRESENT   = 0;
   localparam int FLAG_WRITEABLE = 1;
   localparam int FLAG_KERNEL    = 2;
   localparam int FLAG_GLOBAL    = 3;

   // Page directories are page aligned, so only the page number is kept
   localparam int PAGEDIR_BITS = 20;

endpackage

`default_nettype wire
